// ==== Bender.yml ====
package:
  name: rv32_backend

sources:
  - files:
      - source/rv32_pkg.sv
      - source/rv32_alu.sv
      - source/rv32_pipe_reg.sv
      - source/rv32_regfile.sv
      - source/rv32_hazard.sv
      - source/rv32_execute.sv
      - source/rv32_memory.sv
      - source/rv32_backend.sv
  - target: test
    files:
      - test/rv32_clk_gen.sv
      - test/rv32_backend_sva.sv
      - test/rv32_backend_tb.sv

// ==== sim.f ====
source/rv32_pkg.sv
source/rv32_alu.sv
source/rv32_pipe_reg.sv
source/rv32_regfile.sv
source/rv32_hazard.sv
source/rv32_execute.sv
source/rv32_memory.sv
source/rv32_backend.sv
test/rv32_clk_gen.sv
test/rv32_backend_sva.sv
test/rv32_backend_tb.sv

// ==== source/rv32_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_alu import rv32_pkg::*; (
    input alu_op_t op,
    input logic sub_sra,
    input logic src1,
    input logic src2,
    input logic [31:0] pc,
    input logic [31:0] rs1_value,
    input logic [31:0] rs2_value,
    input logic [31:0] imm,
    output logic [31:0] result
);

    logic [31:0] a;
    logic [31:0] b;
    logic [4:0] shamt;

    assign a = (src1 == SRC1_PC) ? pc : rs1_value;
    assign b = (src2 == SRC2_IMM) ? imm : rs2_value;
    assign shamt = b[4:0];

    always_comb begin
        case (op)
            alu_add: begin
                if (sub_sra) begin
                    result = a - b;
                end else begin
                    result = a + b;
                end
            end
            alu_sll: result = a << shamt;
            // Comparisons give 0 or 1
            alu_slt: result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_xor: result = a ^ b;
            alu_srl: begin
                if (sub_sra) begin
                    result = $unsigned($signed(a) >>> shamt);
                end else begin
                    result = a >> shamt;
                end
            end
            alu_or: result = a | b;
            alu_and: result = a & b;
            // lui
            alu_pass_src2: result = b;
            default: result = 32'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rv32_backend.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_backend import rv32_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input logic clk,
    input logic rst_n,
    input issue_t issue,
    input logic issue_valid,
    output logic issue_ready,
    output logic redirect,
    output logic [31:0] redirect_pc,
    output wb_t wb
);

    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_mem_t ex_mem;
    wb_t wb_next;
    logic id_hold;
    logic id_flush;
    logic ex_flush;

    rv32_regfile i_rv32_regfile (
        .clk(clk),
        .rst_n(rst_n),
        .rs1(issue.rs1),
        .rs2(issue.rs2),
        .rs1_value(rs1_value),
        .rs2_value(rs2_value),
        .wb(wb)
    );

    always_comb begin
        id_ex_d.insn = issue;
        id_ex_d.insn.valid = issue_valid && issue_ready;
        id_ex_d.rs1_value = rs1_value;
        id_ex_d.rs2_value = rs2_value;
    end

    rv32_pipe_reg #(.payload_t(id_ex_t)) i_id_ex (
        .clk(clk),
        .rst_n(rst_n),
        .hold(id_hold),
        .flush(id_flush),
        .d(id_ex_d),
        .q(id_ex_q)
    );

    rv32_execute i_rv32_execute (
        .clk(clk),
        .rst_n(rst_n),
        .flush(ex_flush),
        .id_ex(id_ex_q),
        .wb(wb),
        .ex_mem(ex_mem)
    );

    rv32_memory #(.DMEM_WORDS(DMEM_WORDS)) i_rv32_memory (
        .clk(clk),
        .rst_n(rst_n),
        .ex_mem(ex_mem),
        .wb_next(wb_next),
        .redirect(redirect),
        .redirect_pc(redirect_pc)
    );

    // Nothing stalls past memory
    rv32_pipe_reg #(.payload_t(wb_t)) i_mem_wb (
        .clk(clk),
        .rst_n(rst_n),
        .hold(1'b0),
        .flush(1'b0),
        .d(wb_next),
        .q(wb)
    );

    rv32_hazard i_rv32_hazard (
        .id_rs1(id_ex_q.insn.rs1),
        .id_rs2(id_ex_q.insn.rs2),
        .ex_mem_read(ex_mem.mem_read),
        .ex_rd(ex_mem.rd),
        .redirect(redirect),
        .issue_ready(issue_ready),
        .id_hold(id_hold),
        .id_flush(id_flush),
        .ex_flush(ex_flush)
    );

endmodule

`default_nettype wire

// ==== source/rv32_execute.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_execute import rv32_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic flush,
    input id_ex_t id_ex,
    input wb_t wb,
    output ex_mem_t ex_mem
);

    logic [31:0] rs1_fwd;
    logic [31:0] rs2_fwd;
    logic [31:0] alu_result;
    logic [31:0] branch_base;
    logic kill;
    ex_mem_t ex_mem_d;
    // Last retired write, needed when operands went stale during a stall
    wb_t wb_prev;

    // Youngest producer wins
    function automatic logic [31:0] forward(
        input logic [4:0] rs,
        input logic [31:0] read_value,
        input ex_mem_t own,
        input wb_t wb_now,
        input wb_t wb_old
    );
        logic [31:0] value;
        value = read_value;
        if (rs != 5'd0) begin
            if (own.rd_write && own.rd == rs) begin
                value = own.result;
            end else if (wb_now.valid && wb_now.rd == rs) begin
                value = wb_now.value;
            end else if (wb_old.valid && wb_old.rd == rs) begin
                value = wb_old.value;
            end
        end
        return value;
    endfunction

    assign rs1_fwd = forward(id_ex.insn.rs1, id_ex.rs1_value, ex_mem, wb, wb_prev);
    assign rs2_fwd = forward(id_ex.insn.rs2, id_ex.rs2_value, ex_mem, wb, wb_prev);

    rv32_alu i_rv32_alu (
        .op(id_ex.insn.alu_op),
        .sub_sra(id_ex.insn.alu_sub_sra),
        .src1(id_ex.insn.alu_src1),
        .src2(id_ex.insn.alu_src2),
        .pc(id_ex.insn.pc),
        .rs1_value(rs1_fwd),
        .rs2_value(rs2_fwd),
        .imm(id_ex.insn.imm),
        .result(alu_result)
    );

    assign branch_base = (id_ex.insn.branch_pc_src == BRANCH_BASE_RS1) ? rs1_fwd
                                                                       : id_ex.insn.pc;
    assign kill = flush || !id_ex.insn.valid;

    always_comb begin
        ex_mem_d.mem_read = id_ex.insn.mem_read;
        ex_mem_d.mem_write = id_ex.insn.mem_write;
        ex_mem_d.mem_width = id_ex.insn.mem_width;
        ex_mem_d.mem_zero_extend = id_ex.insn.mem_zero_extend;
        ex_mem_d.branch_op = id_ex.insn.branch_op;
        ex_mem_d.rd = id_ex.insn.rd;
        ex_mem_d.rd_write = id_ex.insn.rd_write;
        ex_mem_d.result = alu_result;
        ex_mem_d.rs2_value = rs2_fwd;
        ex_mem_d.branch_pc = branch_base + id_ex.insn.imm;

        // Bubble: no side effects downstream
        if (kill) begin
            ex_mem_d.mem_read = 1'b0;
            ex_mem_d.mem_write = 1'b0;
            ex_mem_d.rd_write = 1'b0;
            ex_mem_d.branch_op = branch_never;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
            wb_prev <= '0;
        end else begin
            ex_mem <= ex_mem_d;
            wb_prev <= wb;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv32_hazard.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_hazard (
    input logic [4:0] id_rs1,
    input logic [4:0] id_rs2,
    input logic ex_mem_read,
    input logic [4:0] ex_rd,
    input logic redirect,
    output logic issue_ready,
    output logic id_hold,
    output logic id_flush,
    output logic ex_flush
);

    logic load_use;

    // Load data is not ready until writeback
    assign load_use = ex_mem_read && (ex_rd != 5'd0)
                      && (ex_rd == id_rs1 || ex_rd == id_rs2);

    // Redirect wins over the stall
    assign issue_ready = !redirect && !load_use;
    assign id_hold = load_use && !redirect;
    assign id_flush = redirect;
    assign ex_flush = redirect || load_use;

endmodule

`default_nettype wire

// ==== source/rv32_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_memory import rv32_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input logic clk,
    input logic rst_n,
    input ex_mem_t ex_mem,
    output wb_t wb_next,
    output logic redirect,
    output logic [31:0] redirect_pc
);

    localparam int ADDR_BITS = $clog2(DMEM_WORDS);

    logic [31:0] ram [DMEM_WORDS];
    logic [ADDR_BITS-1:0] word_addr;
    logic [1:0] offset;
    logic [31:0] word;
    logic [7:0] load_byte;
    logic [15:0] load_half;
    logic [31:0] load_data;
    logic [3:0] byte_en;
    logic [31:0] store_data;
    logic store_en;

    assign word_addr = ex_mem.result[ADDR_BITS+1:2];
    assign offset = ex_mem.result[1:0];
    assign word = ram[word_addr];

    // Load lane select and extension
    assign load_byte = word[8*offset +: 8];
    assign load_half = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (ex_mem.mem_width)
            mem_byte: begin
                load_data = ex_mem.mem_zero_extend ? {24'b0, load_byte}
                                                   : {{24{load_byte[7]}}, load_byte};
            end
            mem_half: begin
                load_data = ex_mem.mem_zero_extend ? {16'b0, load_half}
                                                   : {{16{load_half[15]}}, load_half};
            end
            default: load_data = word;
        endcase
    end

    // Store lanes come from the low address bits
    always_comb begin
        case (ex_mem.mem_width)
            mem_byte: begin
                byte_en = 4'b0001 << offset;
                store_data = {4{ex_mem.rs2_value[7:0]}};
            end
            mem_half: begin
                byte_en = offset[1] ? 4'b1100 : 4'b0011;
                store_data = {2{ex_mem.rs2_value[15:0]}};
            end
            default: begin
                byte_en = 4'b1111;
                store_data = ex_mem.rs2_value;
            end
        endcase
    end

    assign store_en = ex_mem.mem_write && rst_n;

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (store_en && byte_en[i]) begin
                ram[word_addr][8*i +: 8] <= store_data[8*i +: 8];
            end
        end
    end

    always_comb begin
        case (ex_mem.branch_op)
            branch_always: redirect = 1'b1;
            branch_zero: redirect = (ex_mem.result == 32'b0);
            branch_non_zero: redirect = (ex_mem.result != 32'b0);
            default: redirect = 1'b0;
        endcase
    end

    assign redirect_pc = ex_mem.branch_pc;

    assign wb_next.valid = ex_mem.rd_write && (ex_mem.rd != 5'd0);
    assign wb_next.rd = ex_mem.rd;
    assign wb_next.value = ex_mem.mem_read ? load_data : ex_mem.result;

endmodule

`default_nettype wire

// ==== source/rv32_pipe_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_pipe_reg #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rst_n,
    input logic hold,
    input logic flush,
    input payload_t d,
    output payload_t q
);

    // All-zero payload is a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== source/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_or,
        alu_and,
        alu_pass_src2
    } alu_op_t;

    // Taken is decided from the ALU result
    typedef enum logic [1:0] {
        branch_never,
        branch_always,
        branch_zero,
        branch_non_zero
    } branch_op_t;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word
    } mem_width_t;

    // Operand and base selects
    localparam logic SRC1_RS1 = 1'b0;
    localparam logic SRC1_PC = 1'b1;
    localparam logic SRC2_RS2 = 1'b0;
    localparam logic SRC2_IMM = 1'b1;
    localparam logic BRANCH_BASE_PC = 1'b0;
    localparam logic BRANCH_BASE_RS1 = 1'b1;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic rd_write;
        logic [31:0] imm;
        alu_op_t alu_op;
        logic alu_sub_sra;
        logic alu_src1;
        logic alu_src2;
        logic mem_read;
        logic mem_write;
        mem_width_t mem_width;
        logic mem_zero_extend;
        branch_op_t branch_op;
        logic branch_pc_src;
    } issue_t;

    typedef struct packed {
        issue_t insn;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } id_ex_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        mem_width_t mem_width;
        logic mem_zero_extend;
        branch_op_t branch_op;
        logic [4:0] rd;
        logic rd_write;
        logic [31:0] result;
        logic [31:0] rs2_value;
        logic [31:0] branch_pc;
    } ex_mem_t;

    typedef struct packed {
        logic valid;
        logic [4:0] rd;
        logic [31:0] value;
    } wb_t;

endpackage

`default_nettype wire

// ==== source/rv32_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_regfile import rv32_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic [4:0] rs1,
    input logic [4:0] rs2,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    input wb_t wb
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'b0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Write in the same cycle passes through
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1_value = 32'b0;
        end else if (wb.valid && wb.rd == rs1) begin
            rs1_value = wb.value;
        end else begin
            rs1_value = regs[rs1];
        end

        if (rs2 == 5'd0) begin
            rs2_value = 32'b0;
        end else if (wb.valid && wb.rd == rs2) begin
            rs2_value = wb.value;
        end else begin
            rs2_value = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== test/rv32_backend_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_backend_sva import rv32_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic issue_ready,
    input logic redirect,
    input wb_t wb
);

    // Redirect is a single-cycle pulse
    redirect_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !redirect)
        else $error("redirect stayed high for two cycles");

    redirect_blocks_issue: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> !issue_ready)
        else $error("issue_ready high while redirect is high");

    wb_rd_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wb.valid |-> wb.rd != 5'd0)
        else $error("writeback strobe targets x0");

endmodule

bind rv32_backend rv32_backend_sva i_rv32_backend_sva (
    .clk(clk),
    .rst_n(rst_n),
    .issue_ready(issue_ready),
    .redirect(redirect),
    .wb(wb)
);

`default_nettype wire

// ==== test/rv32_backend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_backend_tb import rv32_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int RAND_LEN = 60;

    logic clk;
    logic rst_n;
    issue_t issue;
    logic issue_valid;
    logic issue_ready;
    logic redirect;
    logic [31:0] redirect_pc;
    wb_t wb;

    issue_t prog [0:255];
    int prog_len;
    logic [31:0] xr [0:31];
    logic [31:0] mem_model [0:255];
    wb_t exp_wb [$];
    logic [31:0] exp_redir [$];
    int fetch_pc;
    logic running;
    logic advance;
    int checks;
    int errors;
    int wb_seen;
    int cycle_limit;
    int cycles;

    rv32_clk_gen #(.PERIOD(8ns), .RESET_CYCLES(2)) i_rv32_clk_gen (.clk(clk), .rst_n(rst_n));

    rv32_backend #(.DMEM_WORDS(256)) i_rv32_backend (
        .clk(clk),
        .rst_n(rst_n),
        .issue(issue),
        .issue_valid(issue_valid),
        .issue_ready(issue_ready),
        .redirect(redirect),
        .redirect_pc(redirect_pc),
        .wb(wb)
    );

    function automatic issue_t alu(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2,
                                   logic [31:0] imm, alu_op_t op, logic sub, logic use_imm);
        issue_t i;
        i = '0;
        i.rd = rd;
        i.rs1 = rs1;
        i.rs2 = rs2;
        i.imm = imm;
        i.alu_op = op;
        i.alu_sub_sra = sub;
        i.alu_src2 = use_imm ? SRC2_IMM : SRC2_RS2;
        i.rd_write = 1'b1;
        return i;
    endfunction

    function automatic issue_t ld(logic [4:0] rd, logic [4:0] rs1, logic [31:0] imm,
                                  mem_width_t width, logic zext);
        issue_t i;
        i = alu(rd, rs1, 5'd0, imm, alu_add, 1'b0, 1'b1);
        i.mem_read = 1'b1;
        i.mem_width = width;
        i.mem_zero_extend = zext;
        return i;
    endfunction

    function automatic issue_t st(logic [4:0] rs2, logic [4:0] rs1, logic [31:0] imm,
                                  mem_width_t width);
        issue_t i;
        i = alu(5'd0, rs1, rs2, imm, alu_add, 1'b0, 1'b1);
        i.rd_write = 1'b0;
        i.mem_write = 1'b1;
        i.mem_width = width;
        return i;
    endfunction

    // Branch compares rs1 and rs2 in the ALU and jumps to base plus imm
    function automatic issue_t br(logic [4:0] rs1, logic [4:0] rs2, alu_op_t op, logic sub,
                                  branch_op_t kind, logic base, logic [31:0] imm);
        issue_t i;
        i = alu(5'd0, rs1, rs2, imm, op, sub, 1'b0);
        i.rd_write = 1'b0;
        i.branch_op = kind;
        i.branch_pc_src = base;
        return i;
    endfunction

    task automatic emit(issue_t i);
        i.valid = 1'b1;
        i.pc = prog_len * 4;
        prog[prog_len] = i;
        prog_len++;
    endtask

    function automatic logic [31:0] alu_ref(alu_op_t op, logic sub, logic [31:0] a,
                                            logic [31:0] b);
        logic [31:0] r;
        case (op)
            alu_add: r = sub ? a - b : a + b;
            alu_sll: r = a << b[4:0];
            alu_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: r = (a < b) ? 32'd1 : 32'd0;
            alu_xor: r = a ^ b;
            alu_srl: begin
                if (sub) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            alu_or: r = a | b;
            alu_and: r = a & b;
            default: r = b;
        endcase
        return r;
    endfunction

    // Interprets the loaded program in order and queues the expected results
    function automatic void run_reference();
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] w;
        logic [31:0] target;
        logic taken;
        issue_t i;
        int steps;
        pc = 0;
        steps = 0;
        while (pc < prog_len * 4 && steps < 4096) begin
            i = prog[pc >> 2];
            steps++;
            a = (i.alu_src1 == SRC1_PC) ? pc : xr[i.rs1];
            b = (i.alu_src2 == SRC2_IMM) ? i.imm : xr[i.rs2];
            r = alu_ref(i.alu_op, i.alu_sub_sra, a, b);
            target = ((i.branch_pc_src == BRANCH_BASE_RS1) ? xr[i.rs1] : pc) + i.imm;
            w = mem_model[r[9:2]];
            v = r;
            if (i.mem_read) begin
                case (i.mem_width)
                    mem_byte: v = i.mem_zero_extend ? {24'b0, w[8*r[1:0] +: 8]}
                                                    : {{24{w[8*r[1:0]+7]}}, w[8*r[1:0] +: 8]};
                    mem_half: begin
                        v = r[1] ? {16'b0, w[31:16]} : {16'b0, w[15:0]};
                        if (!i.mem_zero_extend) v = {{16{v[15]}}, v[15:0]};
                    end
                    default: v = w;
                endcase
            end
            if (i.mem_write) begin
                case (i.mem_width)
                    mem_byte: w[8*r[1:0] +: 8] = xr[i.rs2][7:0];
                    mem_half: w[16*r[1] +: 16] = xr[i.rs2][15:0];
                    default: w = xr[i.rs2];
                endcase
                mem_model[r[9:2]] = w;
            end
            if (i.rd_write && i.rd != 5'd0) begin
                xr[i.rd] = v;
                exp_wb.push_back('{valid: 1'b1, rd: i.rd, value: v});
            end
            case (i.branch_op)
                branch_always: taken = 1'b1;
                branch_zero: taken = (r == 32'b0);
                branch_non_zero: taken = (r != 32'b0);
                default: taken = 1'b0;
            endcase
            if (taken) begin
                exp_redir.push_back(target);
                pc = target;
            end else begin
                pc = pc + 4;
            end
        end
    endfunction

    task automatic build_random();
        int end_pc;
        int k;
        mem_width_t width;
        logic [31:0] off;
        alu_op_t op;
        issue_t insn;
        for (int n = 0; n < 16; n++) begin
            emit(st(5'd0, 5'd0, 32'h100 + 4 * n, mem_word));
        end
        end_pc = (16 + RAND_LEN) * 4;
        for (int n = 0; n < RAND_LEN; n++) begin
            k = $urandom_range(0, 9);
            width = mem_width_t'($urandom_range(0, 2));
            off = $urandom_range(0, 63) & (width == mem_byte ? 63 : width == mem_half ? 62 : 60);
            op = alu_op_t'($urandom_range(0, 8));
            if (k <= 5) begin
                insn = alu($urandom_range(0, 15), $urandom_range(0, 15), $urandom_range(0, 15),
                           $urandom, op, (op == alu_add || op == alu_srl) && $urandom_range(0, 1),
                           $urandom_range(0, 1));
                insn.alu_src1 = ($urandom_range(0, 7) == 0) ? SRC1_PC : SRC1_RS1;
                emit(insn);
            end else if (k == 6) begin
                emit(ld($urandom_range(0, 15), 5'd0, 32'h100 + off, width, $urandom_range(0, 1)));
            end else if (k == 7) begin
                emit(st($urandom_range(0, 15), 5'd0, 32'h100 + off, width));
            end else if (k == 8) begin
                off = 4 * $urandom_range(1, 3);
                if (prog_len * 4 + off > end_pc) off = end_pc - prog_len * 4;
                op = ($urandom_range(0, 1) != 0) ? alu_add : alu_sltu;
                emit(br($urandom_range(0, 15), $urandom_range(0, 15), op, op == alu_add,
                         branch_op_t'($urandom_range(1, 3)), BRANCH_BASE_PC, off));
            end else begin
                emit(alu($urandom_range(1, 15), 5'd0, 5'd0, $urandom, alu_pass_src2, 1'b0, 1'b1));
            end
        end
    endtask

    task automatic build_program(int t);
        prog_len = 0;
        case (t)
            0: begin
                emit(alu(1, 0, 0, 32'h8000_0000, alu_pass_src2, 0, 1));
                emit(alu(2, 0, 0, -7, alu_add, 0, 1));
                emit(alu(3, 1, 2, 0, alu_add, 0, 0));
                emit(alu(4, 2, 1, 0, alu_add, 1, 0));
                emit(alu(5, 1, 0, 4, alu_srl, 1, 1));
                emit(alu(6, 1, 0, 4, alu_srl, 0, 1));
                emit(alu(7, 2, 0, 0, alu_slt, 0, 0));
                emit(alu(8, 2, 1, 0, alu_sltu, 0, 0));
                emit(alu(9, 2, 0, 32'h0f0, alu_xor, 0, 1));
                emit(alu(9, 9, 2, 0, alu_or, 0, 0));
                emit(alu(9, 9, 0, 32'hff, alu_and, 0, 1));
                emit(alu(9, 9, 0, 3, alu_sll, 0, 1));
            end
            1: begin
                emit(alu(10, 0, 0, 1, alu_add, 0, 1));
                emit(alu(10, 10, 10, 0, alu_add, 0, 0));
                emit(alu(11, 10, 10, 0, alu_add, 0, 0));
                emit(alu(12, 11, 10, 0, alu_add, 1, 0));
                emit(alu(13, 12, 0, 5, alu_add, 0, 1));
                emit(alu(14, 10, 0, 1, alu_add, 0, 1));
                emit(alu(15, 10, 13, 0, alu_add, 0, 0));
                emit(alu(16, 15, 14, 0, alu_xor, 0, 0));
            end
            2: begin
                emit(alu(12, 0, 0, 32'h40, alu_add, 0, 1));
                emit(alu(13, 0, 0, 32'h8765_f321, alu_pass_src2, 0, 1));
                emit(st(13, 12, 0, mem_word));
                emit(st(13, 12, 4, mem_word));
                emit(st(2, 12, 1, mem_byte));
                emit(st(2, 12, 6, mem_half));
                emit(ld(14, 12, 1, mem_byte, 0));
                emit(ld(15, 12, 1, mem_byte, 1));
                emit(ld(16, 12, 6, mem_half, 0));
                emit(ld(17, 12, 6, mem_half, 1));
                emit(ld(18, 12, 4, mem_word, 0));
                emit(alu(19, 18, 18, 0, alu_add, 0, 0));
                emit(ld(20, 12, 0, mem_word, 0));
            end
            3: begin
                emit(alu(21, 0, 0, 3, alu_add, 0, 1));
                emit(br(21, 21, alu_add, 1, branch_zero, BRANCH_BASE_PC, 12));
                emit(alu(22, 0, 0, 1, alu_add, 0, 1));
                emit(alu(22, 0, 0, 2, alu_add, 0, 1));
                emit(br(21, 0, alu_add, 1, branch_non_zero, BRANCH_BASE_PC, 12));
                emit(alu(23, 0, 0, 1, alu_add, 0, 1));
                emit(alu(23, 0, 0, 2, alu_add, 0, 1));
                emit(br(21, 0, alu_slt, 0, branch_non_zero, BRANCH_BASE_PC, 8));
                emit(br(21, 0, alu_slt, 0, branch_zero, BRANCH_BASE_PC, 8));
                emit(alu(24, 0, 0, 1, alu_add, 0, 1));
                emit(alu(25, 0, 0, 48, alu_add, 0, 1));
                emit(br(25, 0, alu_add, 0, branch_always, BRANCH_BASE_RS1, 8));
                emit(alu(26, 0, 0, 1, alu_add, 0, 1));
                emit(alu(26, 0, 0, 2, alu_add, 0, 1));
                emit(alu(27, 0, 0, 9, alu_add, 0, 1));
            end
            4: begin
                emit(alu(0, 0, 0, 5, alu_add, 0, 1));
                emit(alu(28, 0, 0, 0, alu_add, 0, 0));
                emit(alu(0, 28, 0, 7, alu_add, 0, 1));
                emit(alu(29, 0, 0, 1, alu_add, 0, 1));
            end
            default: build_random();
        endcase
    endtask

    // Fetch model that follows redirect and holds while issue_ready is low
    always @(negedge clk) begin
        if (!rst_n) begin
            issue <= '0;
            issue_valid <= 1'b0;
            advance = 1'b0;
        end else begin
            if (advance) fetch_pc += 4;
            advance = 1'b0;
            if (redirect) fetch_pc = redirect_pc;
            if (running && fetch_pc < prog_len * 4) begin
                issue <= prog[fetch_pc / 4];
                issue_valid <= 1'b1;
                advance = issue_ready;
            end else begin
                issue <= '0;
                issue_valid <= 1'b0;
            end
        end
    end

    // Compare writebacks and redirects in order
    always @(negedge clk) begin
        wb_t e;
        if (rst_n && wb.valid) begin
            wb_seen++;
            checks++;
            assert (exp_wb.size() != 0) else begin
                $display("unexpected writeback to x%0d", wb.rd);
                errors++;
            end
            if (exp_wb.size() != 0) begin
                e = exp_wb.pop_front();
                assert (wb.rd == e.rd && wb.value == e.value) else begin
                    $display("MISMATCH wb.rd exp %h got %h, wb.value exp %h got %h",
                             e.rd, wb.rd, e.value, wb.value);
                    errors++;
                end
            end
        end
        if (rst_n && redirect) begin
            checks++;
            assert (exp_redir.size() != 0) else begin
                $display("unexpected redirect to %h", redirect_pc);
                errors++;
            end
            if (exp_redir.size() != 0) begin
                assert (redirect_pc == exp_redir[0]) else begin
                    $display("MISMATCH redirect_pc exp %h got %h", exp_redir[0], redirect_pc);
                    errors++;
                end
                void'(exp_redir.pop_front());
            end
        end
    end

    initial begin
        cycles = 0;
        cycle_limit = 100;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > cycle_limit) begin
                $display("timeout after %0d cycles, pipeline did not finish", cycles);
                $display("Test failed");
                $finish;
            end
        end
    end

    initial begin
        string names [NUM_TESTS];
        int err_start;
        int chk_start;
        int exp_count;
        names = '{"alu", "forwarding", "load_store", "branches", "x0_writes", "random"};
        void'($urandom(32'h4e68_7896));
        issue = '0;
        issue_valid = 1'b0;
        running = 1'b0;
        fetch_pc = 0;
        prog_len = 0;
        checks = 0;
        errors = 0;
        for (int r = 0; r < 32; r++) xr[r] = 32'b0;
        @(posedge rst_n);
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);
            build_program(t);
            run_reference();
            exp_count = exp_wb.size();
            cycle_limit += 40 * prog_len;
            err_start = errors;
            chk_start = checks;
            wb_seen = 0;
            fetch_pc = 0;
            running = 1'b1;
            while (!(fetch_pc >= prog_len * 4 && exp_wb.size() == 0 && exp_redir.size() == 0))
                @(negedge clk);
            repeat (5) @(negedge clk);
            running = 1'b0;
            checks++;
            assert (wb_seen == exp_count) else begin
                $display("MISMATCH wb count exp %h got %h", exp_count, wb_seen);
                errors++;
            end
            $display("%s: %0d checks, %0d errors", names[t], checks - chk_start,
                     errors - err_start);
        end
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/rv32_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv32_clk_gen #(
    parameter realtime PERIOD = 8ns,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire
